// File: hdl/reorder_buffer.sv
`timescale 1ns/1ps

// Reorder buffer subsystem top level
// Only the client ports are visible, the RAM stays inside
module reorder_buffer
  import rob_params_pkg::*;
#(
  parameter int num_entries = num_entries_default,
  parameter int data_width = data_width_default,
  parameter int ram_read_latency = ram_read_latency_default
) (
  input  logic clk,
  input  logic rst_n,

  input  logic alloc_ready,
  output logic alloc_valid,
  output logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] alloc_entry_id,

  input  logic unordered_resp_push_valid,
  input  logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] unordered_resp_push_entry_id,
  input  logic [data_width-1:0] unordered_resp_push_data,

  input  logic reordered_resp_pop_ready,
  output logic reordered_resp_pop_valid,
  output logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] reordered_resp_pop_entry_id,
  output logic [data_width-1:0] reordered_resp_pop_data
);

  localparam int entry_id_width = (num_entries > 1) ? $clog2(num_entries) : 1;

  // Link between the controller and the storage
  rob_ram_if #(
    .entry_id_width (entry_id_width),
    .data_width     (data_width)
  ) ram_bus ();

  rob_ctrl #(
    .num_entries      (num_entries),
    .data_width       (data_width),
    .ram_read_latency (ram_read_latency)
  ) ctrl (
    .clk,
    .rst_n,
    .alloc_ready,
    .alloc_valid,
    .alloc_entry_id,
    .unordered_resp_push_valid,
    .unordered_resp_push_entry_id,
    .unordered_resp_push_data,
    .reordered_resp_pop_ready,
    .reordered_resp_pop_valid,
    .reordered_resp_pop_entry_id,
    .reordered_resp_pop_data,
    .ram (ram_bus.ctrl)
  );

  rob_ram #(
    .num_entries      (num_entries),
    .data_width       (data_width),
    .ram_read_latency (ram_read_latency)
  ) storage (
    .clk,
    .rst_n,
    .ram (ram_bus.ram)
  );

endmodule

// File: hdl/reorder_tracker.sv
`timescale 1ns/1ps

// Hands out entry IDs in order, marks them done out of order and
// releases them again in the order they were allocated
module reorder_tracker
  import rob_flow_pkg::*;
#(
  parameter int num_entries = 8
) (
  input  logic clk,
  input  logic rst_n,

  input  logic alloc_ready,
  output logic alloc_valid,
  output logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] alloc_entry_id,

  input  logic push_valid,
  input  logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] push_entry_id,

  input  logic release_ready,
  output logic release_valid,
  output logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] release_entry_id
);

  localparam int entry_id_width = (num_entries > 1) ? $clog2(num_entries) : 1;
  localparam int count_width = $clog2(num_entries + 1);

  // One life state per entry
  entry_state_e entry_state [num_entries];

  // Tail is the next ID to allocate and head the next ID to release
  logic [entry_id_width-1:0] tail_ptr;
  logic [entry_id_width-1:0] head_ptr;

  // Number of entries that are pending or done
  logic [count_width-1:0] in_use_count;

  logic alloc_beat;
  logic release_beat;

  // IDs count up modulo num_entries, which need not be a power of two
  function automatic logic [entry_id_width-1:0] next_id(
    input logic [entry_id_width-1:0] id
  );
    logic [entry_id_width-1:0] result;
    if (id == entry_id_width'(num_entries - 1)) begin
      result = '0;
    end else begin
      result = id + 1'b1;
    end
    return result;
  endfunction

  // Allocation is possible as long as some entry is still free
  // Entries are freed in order so the tail entry is then free as well
  assign alloc_valid    = (in_use_count != count_width'(num_entries));
  assign alloc_entry_id = tail_ptr;
  assign alloc_beat     = alloc_valid && alloc_ready;

  // The oldest entry leaves only once its response has arrived
  assign release_valid    = (entry_state[head_ptr] == entry_done);
  assign release_entry_id = head_ptr;
  assign release_beat     = release_valid && release_ready;

  // Entry state updates
  // Allocation, push and release never touch the same entry in one cycle,
  // because each one needs the entry in a different state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_entries; i++) begin
        entry_state[i] <= entry_free;
      end
    end else begin
      if (alloc_beat) begin
        entry_state[tail_ptr] <= entry_pending;
      end
      // A push must name a pending entry, so it simply marks it done
      if (push_valid) begin
        entry_state[push_entry_id] <= entry_done;
      end
      if (release_beat) begin
        entry_state[head_ptr] <= entry_free;
      end
    end
  end

  // Allocation pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tail_ptr <= '0;
    end else if (alloc_beat) begin
      tail_ptr <= next_id(tail_ptr);
    end
  end

  // Release pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_ptr <= '0;
    end else if (release_beat) begin
      head_ptr <= next_id(head_ptr);
    end
  end

  // Occupancy follows allocations in and releases out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_use_count <= '0;
    end else begin
      unique case ({alloc_beat, release_beat})
        2'b10:   in_use_count <= in_use_count + 1'b1;
        2'b01:   in_use_count <= in_use_count - 1'b1;
        default: in_use_count <= in_use_count;
      endcase
    end
  end

endmodule

// File: hdl/rob_ctrl.sv
`timescale 1ns/1ps

// Reorder buffer controller
// Pushes go straight into the RAM and mark their entry done
// Released entries are read back and staged until the consumer pops them
module rob_ctrl #(
  parameter int num_entries = 8,
  parameter int data_width = 16,
  parameter int ram_read_latency = 2
) (
  input  logic clk,
  input  logic rst_n,

  input  logic alloc_ready,
  output logic alloc_valid,
  output logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] alloc_entry_id,

  input  logic unordered_resp_push_valid,
  input  logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] unordered_resp_push_entry_id,
  input  logic [data_width-1:0] unordered_resp_push_data,

  input  logic reordered_resp_pop_ready,
  output logic reordered_resp_pop_valid,
  output logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] reordered_resp_pop_entry_id,
  output logic [data_width-1:0] reordered_resp_pop_data,

  rob_ram_if.ctrl ram
);

  localparam int entry_id_width = (num_entries > 1) ? $clog2(num_entries) : 1;

  // Enough room to cover the RAM read latency plus the join turnaround
  localparam int staging_depth = ram_read_latency + 2;

  logic                      release_valid;
  logic                      release_ready;
  logic [entry_id_width-1:0] release_entry_id;
  logic                      release_beat;

  logic id_pop_valid;
  logic id_pop_ready;
  logic data_pop_valid;
  logic data_pop_ready;

  reorder_tracker #(
    .num_entries(num_entries)
  ) tracker (
    .clk,
    .rst_n,
    .alloc_ready,
    .alloc_valid,
    .alloc_entry_id,
    .push_valid       (unordered_resp_push_valid),
    .push_entry_id    (unordered_resp_push_entry_id),
    .release_ready    (release_ready),
    .release_valid    (release_valid),
    .release_entry_id (release_entry_id)
  );

  assign release_beat = release_valid && release_ready;

  // The ID FIFO takes one ID per release and its space gates the release
  staging_fifo #(
    .depth     (staging_depth),
    .payload_t (logic [entry_id_width-1:0])
  ) id_fifo (
    .clk,
    .rst_n,
    .push_valid (release_valid),
    .push_data  (release_entry_id),
    .push_ready (release_ready),
    .pop_valid  (id_pop_valid),
    .pop_data   (reordered_resp_pop_entry_id),
    .pop_ready  (id_pop_ready)
  );

  // Same depth and popped together with the ID FIFO so it cannot overflow
  staging_fifo #(
    .depth     (staging_depth),
    .payload_t (logic [data_width-1:0])
  ) data_fifo (
    .clk,
    .rst_n,
    .push_valid (ram.rd_data_valid),
    .push_data  (ram.rd_data),
    .push_ready (),
    .pop_valid  (data_pop_valid),
    .pop_data   (reordered_resp_pop_data),
    .pop_ready  (data_pop_ready)
  );

  // Join of the two FIFO heads into one output beat
  assign reordered_resp_pop_valid = id_pop_valid && data_pop_valid;
  assign id_pop_ready   = reordered_resp_pop_ready && data_pop_valid;
  assign data_pop_ready = reordered_resp_pop_ready && id_pop_valid;

  // Each push is written to the RAM in the cycle it arrives
  assign ram.wr_valid = unordered_resp_push_valid;
  assign ram.wr_addr  = unordered_resp_push_entry_id;
  assign ram.wr_data  = unordered_resp_push_data;

  // Each release reads back the data of the released entry
  assign ram.rd_addr_valid = release_beat;
  assign ram.rd_addr       = release_entry_id;

endmodule

// File: hdl/rob_flow_pkg.sv
package rob_flow_pkg;

  // Life state of one reorder entry
  // An entry goes free -> pending on allocation, pending -> done on a push,
  // and done -> free when it is released in allocation order
  typedef enum logic [1:0] {
    entry_free    = 2'd0,
    entry_pending = 2'd1,
    entry_done    = 2'd2
  } entry_state_e;

endpackage

// File: hdl/rob_params_pkg.sv
package rob_params_pkg;

  // Default sizing of the reorder buffer subsystem
  // The top level takes these as its parameter defaults

  // Number of reorder entries that may be outstanding at once
  localparam int num_entries_default = 8;

  // Width of the data word carried by each response
  localparam int data_width_default = 16;

  // Cycles from a RAM read address to its read data
  localparam int ram_read_latency_default = 2;

endpackage

// File: hdl/rob_ram.sv
`timescale 1ns/1ps

// One-write one-read storage for the response data
// Read data appears ram_read_latency cycles after the read address
module rob_ram #(
  parameter int num_entries = 8,
  parameter int data_width = 16,
  parameter int ram_read_latency = 2
) (
  input logic clk,
  input logic rst_n,
  rob_ram_if.ram ram
);

  // Storage array, one word per reorder entry
  logic [data_width-1:0] mem [num_entries];

  // Stage 0 of the read pipeline holds the word just read from the array
  logic [data_width-1:0]       rd_data_pipe [ram_read_latency];
  logic [ram_read_latency-1:0] rd_valid_pipe;

  always_ff @(posedge clk) begin
    if (ram.wr_valid) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // Stage 0 loads on a read and later stages shift one step per cycle
  always_ff @(posedge clk) begin
    if (ram.rd_addr_valid) begin
      rd_data_pipe[0] <= mem[ram.rd_addr];
    end
    for (int s = 1; s < ram_read_latency; s++) begin
      rd_data_pipe[s] <= rd_data_pipe[s-1];
    end
  end

  // Valid bits travel alongside the data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid_pipe <= '0;
    end else begin
      rd_valid_pipe[0] <= ram.rd_addr_valid;
      for (int s = 1; s < ram_read_latency; s++) begin
        rd_valid_pipe[s] <= rd_valid_pipe[s-1];
      end
    end
  end

  assign ram.rd_data       = rd_data_pipe[ram_read_latency-1];
  assign ram.rd_data_valid = rd_valid_pipe[ram_read_latency-1];

endmodule

// File: hdl/rob_ram_if.sv
`timescale 1ns/1ps

// Write and read ports of the reorder buffer storage RAM
interface rob_ram_if #(
  parameter int entry_id_width = 3,
  parameter int data_width = 16
);

  // Write port driven straight from the unordered response push
  logic                      wr_valid;
  logic [entry_id_width-1:0] wr_addr;
  logic [data_width-1:0]     wr_data;

  // Read address issued once per entry release
  logic                      rd_addr_valid;
  logic [entry_id_width-1:0] rd_addr;

  // Read data returned a fixed number of cycles after the address
  logic [data_width-1:0]     rd_data;
  logic                      rd_data_valid;

  // The controller side issues writes and read addresses
  modport ctrl (
    output wr_valid, wr_addr, wr_data,
    output rd_addr_valid, rd_addr,
    input  rd_data, rd_data_valid
  );

  // The storage side answers them
  modport ram (
    input  wr_valid, wr_addr, wr_data,
    input  rd_addr_valid, rd_addr,
    output rd_data, rd_data_valid
  );

endinterface

// File: hdl/staging_fifo.sv
`timescale 1ns/1ps

// Small FIFO built from flops
// The payload type is a parameter so one module serves both IDs and data
module staging_fifo #(
  parameter int depth = 4,
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_valid,
  input  payload_t push_data,
  output logic     push_ready,
  output logic     pop_valid,
  output payload_t pop_data,
  input  logic     pop_ready
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_width = $clog2(depth + 1);

  // Payload slots are filled at the write pointer and read at the read pointer
  payload_t               slots [depth];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] item_count;
  logic                   push_beat;
  logic                   pop_beat;

  // Pointers wrap explicitly so a depth that is not a power of two works
  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    logic [ptr_width-1:0] result;
    if (ptr == ptr_width'(depth - 1)) begin
      result = '0;
    end else begin
      result = ptr + 1'b1;
    end
    return result;
  endfunction

  assign push_ready = (item_count != count_width'(depth));
  assign pop_valid  = (item_count != '0);
  assign push_beat  = push_valid && push_ready;
  assign pop_beat   = pop_valid && pop_ready;

  // The head slot drives the output directly, one cycle after its push
  assign pop_data = slots[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_beat) begin
      slots[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      item_count <= '0;
    end else begin
      if (push_beat) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_beat) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous push and pop leave the count where it is
      if (push_beat && !pop_beat) begin
        item_count <= item_count + 1'b1;
      end else if (pop_beat && !push_beat) begin
        item_count <= item_count - 1'b1;
      end
    end
  end

endmodule

// File: reorder_buffer.f
hdl/rob_params_pkg.sv
hdl/rob_flow_pkg.sv
hdl/rob_ram_if.sv
hdl/staging_fifo.sv
hdl/reorder_tracker.sv
hdl/rob_ctrl.sv
hdl/rob_ram.sv
hdl/reorder_buffer.sv
test/tb_clock_gen.sv
test/reorder_buffer_checker.sv
test/reorder_buffer_tb.sv

// File: test/reorder_buffer_checker.sv
`timescale 1ns/1ps

// Assertions on the reorder tracker and on the reordered output port
// The module is bound twice and tracker_side picks which checks apply
module reorder_buffer_checker
  import rob_flow_pkg::*;
#(
  parameter int num_entries = 8,
  parameter int data_width = 16,
  parameter bit tracker_side = 1'b1
) (
  input logic clk,
  input logic rst_n,
  input logic push_valid,
  input entry_state_e push_state,
  input logic [$clog2(num_entries + 1)-1:0] in_use_count,
  input logic pop_valid,
  input logic pop_ready,
  input logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] pop_entry_id,
  input logic [data_width-1:0] pop_data
);

  // Number of assertion failures that the testbench adds up at the end
  int failures = 0;

  // A push may only complete an entry that was allocated and is still waiting
  push_names_pending: assert property (@(posedge clk) disable iff (!rst_n)
    (tracker_side && push_valid) |-> (push_state == entry_pending))
    else begin
      failures++;
      $error("push named an entry that is not pending");
    end

  // Occupancy can never pass the number of entries
  in_use_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    tracker_side |-> (in_use_count <= num_entries))
    else begin
      failures++;
      $error("in-use count exceeds the number of entries");
    end

  // A stalled output beat keeps its valid, ID and data
  pop_holds_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (!tracker_side && pop_valid && !pop_ready) |=>
      (pop_valid && $stable(pop_entry_id) && $stable(pop_data)))
    else begin
      failures++;
      $error("reordered output changed while stalled");
    end

endmodule

// The tracker side looks at the state of the entry each push names
bind reorder_tracker reorder_buffer_checker #(
  .num_entries  (num_entries),
  .data_width   (1),
  .tracker_side (1'b1)
) tracker_checks (
  .clk,
  .rst_n,
  .push_valid,
  .push_state   (entry_state[push_entry_id]),
  .in_use_count,
  .pop_valid    (1'b0),
  .pop_ready    (1'b0),
  .pop_entry_id ('0),
  .pop_data     (1'b0)
);

// The output side watches the top-level pop port
bind reorder_buffer reorder_buffer_checker #(
  .num_entries  (num_entries),
  .data_width   (data_width),
  .tracker_side (1'b0)
) output_checks (
  .clk,
  .rst_n,
  .push_valid   (1'b0),
  .push_state   (rob_flow_pkg::entry_free),
  .in_use_count ('0),
  .pop_valid    (reordered_resp_pop_valid),
  .pop_ready    (reordered_resp_pop_ready),
  .pop_entry_id (reordered_resp_pop_entry_id),
  .pop_data     (reordered_resp_pop_data)
);

// File: test/reorder_buffer_tb.sv
`timescale 1ns/1ps

// Table-driven testbench for the reorder buffer with an in-order scoreboard
module reorder_buffer_tb
  import rob_params_pkg::*;
();

  localparam int num_entries = num_entries_default;
  localparam int data_width = data_width_default;
  localparam int id_width = (num_entries > 1) ? $clog2(num_entries) : 1;
  localparam int num_rows = 6;
  localparam int timeout_cycles = 200;

  // Test table with one column per array
  // Order 0 is in order, 1 reversed, 2 random; ready 0 is always, 1 alternating, 2 random
  string row_name [num_rows] = '{"in_order_full", "reversed_alt", "random_rand",
                                 "random_partial", "reversed_partial", "in_order_alt"};
  int row_count [num_rows] = '{8, 8, 8, 5, 3, 6};
  int row_order [num_rows] = '{0, 1, 2, 2, 1, 0};
  int row_ready [num_rows] = '{0, 1, 2, 0, 2, 1};

  logic clk;
  logic rst_n;
  logic alloc_ready;
  logic alloc_valid;
  logic [id_width-1:0] alloc_entry_id;
  logic push_valid;
  logic [id_width-1:0] push_entry_id;
  logic [data_width-1:0] push_data;
  logic pop_ready;
  logic pop_valid;
  logic [id_width-1:0] pop_entry_id;
  logic [data_width-1:0] pop_data;

  int errors;
  int assert_failures;
  bit timed_out;
  bit [31:0] rng_state;
  int next_expected_id;
  bit pushed [num_entries];
  // IDs in allocation order, which is also the expected pop order
  logic [id_width-1:0] alloc_ids [$];
  logic [id_width-1:0] push_order [$];

  tb_clock_gen #(.period_ns(20.0)) clock (.clk);

  reorder_buffer #(
    .num_entries      (num_entries),
    .data_width       (data_width),
    .ram_read_latency (ram_read_latency_default)
  ) dut (
    .clk,
    .rst_n,
    .alloc_ready,
    .alloc_valid,
    .alloc_entry_id,
    .unordered_resp_push_valid    (push_valid),
    .unordered_resp_push_entry_id (push_entry_id),
    .unordered_resp_push_data     (push_data),
    .reordered_resp_pop_ready     (pop_ready),
    .reordered_resp_pop_valid     (pop_valid),
    .reordered_resp_pop_entry_id  (pop_entry_id),
    .reordered_resp_pop_data      (pop_data)
  );

  function automatic bit [31:0] xorshift32(input bit [31:0] x);
    bit [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Response data differs per ID and per row so stale words show up
  function automatic logic [data_width-1:0] data_for(input int id, input int row);
    return data_width'((row + 1) * 32'h1000 + id * 32'h0107 + 32'h00a5);
  endfunction

  task automatic allocate_row(input int row);
    int waited;
    for (int k = 0; k < row_count[row] && !timed_out; k++) begin
      @(negedge clk);
      alloc_ready = 1'b1;
      #1;
      waited = 0;
      while (!alloc_valid && !timed_out) begin
        waited++;
        if (waited > timeout_cycles) begin
          $display("Timeout in %s while waiting for alloc_valid", row_name[row]);
          errors++;
          timed_out = 1'b1;
        end else begin
          @(negedge clk);
          #1;
        end
      end
      if (!timed_out) begin
        if (alloc_entry_id !== id_width'(next_expected_id)) begin
          $display("FAIL %s alloc_entry_id: expected %0d actual %0d", row_name[row],
                   next_expected_id, alloc_entry_id);
          errors++;
        end
        alloc_ids.push_back(alloc_entry_id);
        next_expected_id = (next_expected_id + 1) % num_entries;
      end
    end
    @(negedge clk);
    alloc_ready = 1'b0;
    #1;
    // Every entry is now outstanding, so allocation must stall
    if (row_count[row] == num_entries && alloc_valid !== 1'b0) begin
      $display("FAIL %s alloc_valid when full: expected 0 actual %b", row_name[row], alloc_valid);
      errors++;
    end
  endtask

  task automatic build_order(input int row);
    int j;
    logic [id_width-1:0] tmp;
    push_order.delete();
    foreach (alloc_ids[i]) begin
      if (row_order[row] == 1) begin
        push_order.push_front(alloc_ids[i]);
      end else begin
        push_order.push_back(alloc_ids[i]);
      end
    end
    // Fisher-Yates shuffle driven by the xorshift stream
    if (row_order[row] == 2) begin
      for (int i = push_order.size() - 1; i > 0; i--) begin
        rng_state = xorshift32(rng_state);
        j = int'(rng_state % (i + 1));
        tmp = push_order[i];
        push_order[i] = push_order[j];
        push_order[j] = tmp;
      end
    end
  endtask

  task automatic push_row(input int row);
    foreach (push_order[i]) begin
      @(negedge clk);
      push_valid = 1'b1;
      push_entry_id = push_order[i];
      push_data = data_for(push_order[i], row);
      pushed[push_order[i]] = 1'b1;
    end
    @(negedge clk);
    push_valid = 1'b0;
  endtask

  task automatic collect_row(input int row);
    int got;
    int waited;
    int cycle;
    logic [id_width-1:0] exp_id;
    got = 0;
    waited = 0;
    cycle = 0;
    while (got < row_count[row] && !timed_out) begin
      @(negedge clk);
      case (row_ready[row])
        0: pop_ready = 1'b1;
        1: pop_ready = cycle[0];
        default: begin
          rng_state = xorshift32(rng_state);
          pop_ready = rng_state[4];
        end
      endcase
      cycle++;
      #1;
      // A beat seen here is taken at the coming rising edge
      if (pop_valid && pop_ready) begin
        exp_id = alloc_ids[got];
        if (pop_entry_id !== exp_id) begin
          $display("FAIL %s pop %0d entry id: expected %0d actual %0d", row_name[row], got,
                   exp_id, pop_entry_id);
          errors++;
        end
        if (pop_data !== data_for(exp_id, row)) begin
          $display("FAIL %s pop %0d data: expected %h actual %h", row_name[row], got,
                   data_for(exp_id, row), pop_data);
          errors++;
        end
        if (!pushed[exp_id]) begin
          $display("Entry %0d in %s was popped before it was pushed", exp_id, row_name[row]);
          errors++;
        end
        got++;
        waited = 0;
      end else begin
        waited++;
        if (waited > timeout_cycles) begin
          $display("Timeout in %s while waiting for pop %0d", row_name[row], got);
          errors++;
          timed_out = 1'b1;
        end
      end
    end
    @(negedge clk);
    pop_ready = 1'b0;
  endtask

  initial begin
    rst_n = 1'b0;
    alloc_ready = 1'b0;
    push_valid = 1'b0;
    push_entry_id = '0;
    push_data = '0;
    pop_ready = 1'b0;
    errors = 0;
    assert_failures = 0;
    timed_out = 1'b0;
    rng_state = 32'h345e639f;
    next_expected_id = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    if (alloc_valid !== 1'b1) begin
      $display("FAIL reset alloc_valid: expected 1 actual %b", alloc_valid);
      errors++;
    end
    if (pop_valid !== 1'b0) begin
      $display("FAIL reset pop_valid: expected 0 actual %b", pop_valid);
      errors++;
    end
    for (int row = 0; row < num_rows && !timed_out; row++) begin
      alloc_ids.delete();
      foreach (pushed[i]) begin
        pushed[i] = 1'b0;
      end
      allocate_row(row);
      if (!timed_out) begin
        build_order(row);
        fork
          push_row(row);
          collect_row(row);
        join
        #1;
        // Nothing may be left over and every entry is free again
        if (pop_valid !== 1'b0) begin
          $display("FAIL %s extra pop_valid: expected 0 actual %b", row_name[row], pop_valid);
          errors++;
        end
        if (alloc_valid !== 1'b1) begin
          $display("FAIL %s alloc_valid after pops: expected 1 actual %b", row_name[row],
                   alloc_valid);
          errors++;
        end
      end
    end
    assert_failures = dut.output_checks.failures + dut.ctrl.tracker.tracker_checks.failures;
    $display("Run finished with %0d check errors and %0d assertion failures", errors,
             assert_failures);
    if (errors == 0 && assert_failures == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

// Free-running clock for the testbench
module tb_clock_gen #(
  parameter real period_ns = 20.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Half a period low, half a period high
  always #(period_ns / 2.0) clk = ~clk;

endmodule
